// File: Makefile
TOP := tb_mempool_system

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	@grep -q "TESTS PASSED" sim.log || (echo "Simulation did not pass, see sim.log"; exit 1)

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)
	verilator --lint-only -f all.f --top-module mempool_system

clean:
	rm -rf obj_dir sim.log

// File: all.f
hdl/mempool_sys_pkg.sv
hdl/addr_decoder.sv
hdl/l2_mem.sv
hdl/bootrom.sv
hdl/ctrl_registers.sv
hdl/mempool_system.sv
test/tb_clock_gen.sv
test/tb_mempool_system.sv

// File: hdl/addr_decoder.sv
`timescale 1ns/100ps
// Host port address decoder with grant control
// and in-order response steering
module addr_decoder
  import mempool_sys_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Host port
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  strb_t be_i,
  output logic  gnt_o,
  output logic  rvalid_o,
  output data_t rdata_o,
  // External port
  output logic  ext_req_o,
  output logic  ext_we_o,
  output addr_t ext_addr_o,
  output data_t ext_wdata_o,
  output strb_t ext_be_o,
  input  logic  ext_gnt_i,
  input  logic  ext_rvalid_i,
  input  data_t ext_rdata_i,
  // Internal targets
  output logic  l2_req_o,
  output logic  rom_req_o,
  output logic  ctrl_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  output strb_t mem_be_o,
  input  logic  l2_rvalid_i,
  input  data_t l2_rdata_i,
  input  logic  rom_rvalid_i,
  input  data_t rom_rdata_i,
  input  logic  ctrl_rvalid_i,
  input  data_t ctrl_rdata_i
);

  target_e req_tgt;
  target_e resp_tgt_q;    // Source of the next response
  logic    ext_sel;
  logic    int_due_q;     // Internal response due this cycle
  logic    ext_pending_q; // External request outstanding
  logic    accept;

  // Map lookup, anything unmapped goes outside
  always_comb begin
    req_tgt = TgtExternal;
    if (addr_i >= CtrlBaseAddr && addr_i <= CtrlEndAddr) begin
      req_tgt = TgtCtrl;
    end else if (addr_i >= L2BaseAddr && addr_i < L2EndAddr) begin
      req_tgt = TgtL2;
    end else if (addr_i >= BootromBaseAddr && addr_i <= BootromEndAddr) begin
      req_tgt = TgtBootrom;
    end
  end

  assign ext_sel = (req_tgt == TgtExternal);

  // External requests wait for the previous external and any internal response
  assign ext_req_o = req_i && ext_sel && !ext_pending_q && !int_due_q;
  assign gnt_o     = ext_sel ? (ext_req_o && ext_gnt_i) : !ext_pending_q;
  assign accept    = req_i && gnt_o;

  assign l2_req_o   = req_i && (req_tgt == TgtL2) && !ext_pending_q;
  assign rom_req_o  = req_i && (req_tgt == TgtBootrom) && !ext_pending_q;
  assign ctrl_req_o = req_i && (req_tgt == TgtCtrl) && !ext_pending_q;

  assign mem_we_o    = we_i;
  assign mem_addr_o  = addr_i;
  assign mem_wdata_o = wdata_i;
  assign mem_be_o    = be_i;

  assign ext_we_o    = we_i;
  assign ext_addr_o  = addr_i;
  assign ext_wdata_o = wdata_i;
  assign ext_be_o    = be_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_tgt_q    <= TgtCtrl;
      int_due_q     <= 1'b0;
      ext_pending_q <= 1'b0;
    end else begin
      int_due_q <= accept && !ext_sel;
      if (accept) begin
        resp_tgt_q <= req_tgt;
      end
      if (accept && ext_sel) begin
        ext_pending_q <= 1'b1;
      end else if (ext_rvalid_i) begin
        ext_pending_q <= 1'b0; // External response seen
      end
    end
  end

  // Response steering by the source of the oldest request
  always_comb begin
    unique case (resp_tgt_q)
      TgtCtrl: begin
        rvalid_o = ctrl_rvalid_i;
        rdata_o  = ctrl_rdata_i;
      end
      TgtL2: begin
        rvalid_o = l2_rvalid_i;
        rdata_o  = l2_rdata_i;
      end
      TgtBootrom: begin
        rvalid_o = rom_rvalid_i;
        rdata_o  = rom_rdata_i;
      end
      default: begin
        rvalid_o = ext_rvalid_i;
        rdata_o  = ext_rdata_i;
      end
    endcase
  end

endmodule : addr_decoder

// File: hdl/bootrom.sv
`timescale 1ns/100ps
// Boot ROM with generated contents and registered response
module bootrom
  import mempool_sys_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  req_i,
  input  addr_t addr_i,
  output logic  rvalid_o,
  output data_t rdata_o
);

  data_t    rom [BootromNumWords];
  rom_idx_t idx;
  data_t    rdata_q;
  logic     rvalid_q;

  // Word k holds the tag above its own index
  for (genvar k = 0; k < BootromNumWords; k++) begin : gen_rom
    assign rom[k] = {BootromTag, 16'(k)};
  end

  assign idx = addr_i[ByteOffsWidth +: RomIdxWidth]; // Wraps above the last word

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= rom[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule : bootrom

// File: hdl/ctrl_registers.sv
`timescale 1ns/100ps
// Control registers: core wake-up pulse, end of computation
// and a read-only core count
module ctrl_registers
  import mempool_sys_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       req_i,
  input  logic       we_i,
  input  addr_t      addr_i,
  input  data_t      wdata_i,
  output logic       rvalid_o,
  output data_t      rdata_o,
  output core_mask_t wake_up_o,
  output logic       eoc_valid_o
);

  logic [CtrlOffsWidth-1:0] offs;
  logic                     wr_en;
  data_t                    rd_word;
  data_t                    rdata_q;
  data_t                    eoc_q;
  core_mask_t               wake_up_q;
  logic                     rvalid_q;

  assign offs  = addr_i[CtrlOffsWidth-1:0];
  assign wr_en = req_i && we_i;

  // Read view of the register map
  always_comb begin
    case (offs)
      CtrlEocOffs:      rd_word = eoc_q;
      CtrlNumCoresOffs: rd_word = data_t'(NumCores);
      default:          rd_word = '0; // Wake-up reads as zero
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q  <= 1'b0;
      wake_up_q <= '0;
      eoc_q     <= '0;
    end else begin
      rvalid_q <= req_i;
      // One-cycle pulse, cleared on the next edge
      wake_up_q <= (wr_en && offs == CtrlWakeUpOffs) ? wdata_i[NumCores-1:0] : '0;
      if (wr_en && offs == CtrlEocOffs) begin
        eoc_q <= wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= rd_word;
    end
  end

  assign rvalid_o    = rvalid_q;
  assign rdata_o     = rdata_q;
  assign wake_up_o   = wake_up_q;
  assign eoc_valid_o = eoc_q[0];

endmodule : ctrl_registers

// File: hdl/l2_mem.sv
`timescale 1ns/100ps
// Word-interleaved L2 memory with byte-enabled banks
// and a single-cycle registered response
module l2_mem
  import mempool_sys_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  strb_t be_i,
  output logic  rvalid_o,
  output data_t rdata_o
);

  logic [L2BankSelWidth-1:0] bank_sel;
  logic [L2BankSelWidth-1:0] bank_sel_q; // Bank of the pending read
  l2_row_t                   row;
  logic [NumL2Banks-1:0]     bank_req;
  data_t                     bank_rdata [NumL2Banks];
  logic                      rvalid_q;

  // Low word bits pick the bank, the bits above pick the row
  assign bank_sel = addr_i[ByteOffsWidth +: L2BankSelWidth];
  assign row      = addr_i[ByteOffsWidth + L2BankSelWidth +: L2RowWidth];

  for (genvar i = 0; i < NumL2Banks; i++) begin : gen_banks
    data_t mem [L2BankNumWords];

    assign bank_req[i] = req_i && (bank_sel == L2BankSelWidth'(i));

    always_ff @(posedge clk_i) begin
      if (bank_req[i]) begin
        if (we_i) begin
          for (int b = 0; b < StrbWidth; b++) begin
            if (be_i[b]) begin
              mem[row][8*b +: 8] <= wdata_i[8*b +: 8];
            end
          end
        end else begin
          bank_rdata[i] <= mem[row];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      bank_sel_q <= bank_sel;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i; // Writes answer as well
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = bank_rdata[bank_sel_q];

endmodule : l2_mem

// File: hdl/mempool_sys_pkg.sv
// Widths, address map, memory sizes and decode target
// shared by the memory system modules
package mempool_sys_pkg;

  // Bus widths
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned StrbWidth     = DataWidth / 8;
  localparam int unsigned ByteOffsWidth = $clog2(StrbWidth);
  localparam int unsigned NumCores      = 8;

  // L2 geometry, word interleaved across banks
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankNumWords = 256;
  localparam int unsigned L2BankSelWidth = $clog2(NumL2Banks);
  localparam int unsigned L2RowWidth     = $clog2(L2BankNumWords);
  localparam int unsigned L2Size         = NumL2Banks * L2BankNumWords * StrbWidth;

  // Boot ROM
  localparam int unsigned BootromNumWords = 16;
  localparam int unsigned RomIdxWidth     = $clog2(BootromNumWords);

  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [DataWidth-1:0]  data_t;
  typedef logic [StrbWidth-1:0]  strb_t;
  typedef logic [NumCores-1:0]   core_mask_t;
  typedef logic [L2RowWidth-1:0] l2_row_t;
  typedef logic [RomIdxWidth-1:0] rom_idx_t;

  // Address map
  localparam addr_t CtrlBaseAddr    = 32'h4000_0000;
  localparam addr_t CtrlEndAddr     = 32'h4000_FFFF;
  localparam addr_t L2BaseAddr      = 32'h8000_0000;
  localparam addr_t L2EndAddr       = L2BaseAddr + addr_t'(L2Size); // Exclusive
  localparam addr_t BootromBaseAddr = 32'hA000_0000;
  localparam addr_t BootromEndAddr  = 32'hA000_FFFF;

  localparam logic [15:0] BootromTag = 16'hB007; // Upper half of every ROM word

  // Control register offsets within the low address bits
  localparam int unsigned CtrlOffsWidth = 16;
  localparam logic [CtrlOffsWidth-1:0] CtrlWakeUpOffs   = 16'h0000;
  localparam logic [CtrlOffsWidth-1:0] CtrlEocOffs      = 16'h0004;
  localparam logic [CtrlOffsWidth-1:0] CtrlNumCoresOffs = 16'h0008;

  // Decode target of a host request
  typedef enum logic [1:0] {
    TgtCtrl,
    TgtL2,
    TgtBootrom,
    TgtExternal
  } target_e;

endpackage : mempool_sys_pkg

// File: hdl/mempool_system.sv
`timescale 1ns/100ps
// Memory system top level
// Address decoder, banked L2, boot ROM and control registers
module mempool_system
  import mempool_sys_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Host port
  input  logic       req_i,
  input  logic       we_i,
  input  addr_t      addr_i,
  input  data_t      wdata_i,
  input  strb_t      be_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  output data_t      rdata_o,
  // External port
  output logic       ext_req_o,
  output logic       ext_we_o,
  output addr_t      ext_addr_o,
  output data_t      ext_wdata_o,
  output strb_t      ext_be_o,
  input  logic       ext_gnt_i,
  input  logic       ext_rvalid_i,
  input  data_t      ext_rdata_i,
  // Control outputs
  output core_mask_t wake_up_o,
  output logic       eoc_valid_o
);

  // Shared request wires towards the internal targets
  logic  mem_we;
  addr_t mem_addr;
  data_t mem_wdata;
  strb_t mem_be;

  logic  l2_req, rom_req, ctrl_req;
  logic  l2_rvalid, rom_rvalid, ctrl_rvalid;
  data_t l2_rdata, rom_rdata, ctrl_rdata;

  addr_decoder i_addr_decoder (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .req_i        (req_i       ),
    .we_i         (we_i        ),
    .addr_i       (addr_i      ),
    .wdata_i      (wdata_i     ),
    .be_i         (be_i        ),
    .gnt_o        (gnt_o       ),
    .rvalid_o     (rvalid_o    ),
    .rdata_o      (rdata_o     ),
    .ext_req_o    (ext_req_o   ),
    .ext_we_o     (ext_we_o    ),
    .ext_addr_o   (ext_addr_o  ),
    .ext_wdata_o  (ext_wdata_o ),
    .ext_be_o     (ext_be_o    ),
    .ext_gnt_i    (ext_gnt_i   ),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i ),
    .l2_req_o     (l2_req      ),
    .rom_req_o    (rom_req     ),
    .ctrl_req_o   (ctrl_req    ),
    .mem_we_o     (mem_we      ),
    .mem_addr_o   (mem_addr    ),
    .mem_wdata_o  (mem_wdata   ),
    .mem_be_o     (mem_be      ),
    .l2_rvalid_i  (l2_rvalid   ),
    .l2_rdata_i   (l2_rdata    ),
    .rom_rvalid_i (rom_rvalid  ),
    .rom_rdata_i  (rom_rdata   ),
    .ctrl_rvalid_i(ctrl_rvalid ),
    .ctrl_rdata_i (ctrl_rdata  )
  );

  l2_mem i_l2_mem (
    .clk_i   (clk_i    ),
    .rst_n_i (rst_n_i  ),
    .req_i   (l2_req   ),
    .we_i    (mem_we   ),
    .addr_i  (mem_addr ),
    .wdata_i (mem_wdata),
    .be_i    (mem_be   ),
    .rvalid_o(l2_rvalid),
    .rdata_o (l2_rdata )
  );

  bootrom i_bootrom (
    .clk_i   (clk_i     ),
    .rst_n_i (rst_n_i   ),
    .req_i   (rom_req   ),
    .addr_i  (mem_addr  ),
    .rvalid_o(rom_rvalid),
    .rdata_o (rom_rdata )
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_i      (ctrl_req   ),
    .we_i       (mem_we     ),
    .addr_i     (mem_addr   ),
    .wdata_i    (mem_wdata  ),
    .rvalid_o   (ctrl_rvalid),
    .rdata_o    (ctrl_rdata ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

endmodule : mempool_system

// File: test/tb_clock_gen.sv
`timescale 1ns/100ps
// Testbench clock (100 ns period) and synchronous reset for two cycles
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o <= 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule : tb_clock_gen

// File: test/tb_mempool_system.sv
`timescale 1ns/100ps
// Directed testbench for the memory system, with a model of the
// external target on the forwarding port
module tb_mempool_system
  import mempool_sys_pkg::*;
();

  localparam int Timeout = 50; // Cycles per wait

  logic       clk, rst_n;
  logic       req, we, gnt, rvalid;
  addr_t      addr;
  data_t      wdata, rdata;
  strb_t      be;
  logic       ext_req, ext_we, ext_gnt, ext_rvalid;
  addr_t      ext_addr;
  data_t      ext_wdata, ext_rdata;
  strb_t      ext_be;
  core_mask_t wake_up;
  logic       eoc_valid;

  integer     seed;
  int         cycle, errors, checks, test_errors, int_rsp_cnt, ext_cnt;
  int         grant_delay [64]; // External target timing drawn up front
  int         resp_delay [64];
  data_t      rsp_data [$];
  int         rsp_cycle [$];
  int         wake_cycle [$];
  core_mask_t wake_val [$];
  data_t      l2_model [int];   // Expected L2 contents by word index
  data_t      ext_mem [addr_t];
  data_t      ext_word0;        // Expected word at 0x1000_0000
  logic       last_we;
  addr_t      last_addr;
  data_t      last_wdata;
  strb_t      last_be;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk  ),
    .rst_n_o(rst_n)
  );

  mempool_system dut (
    .clk_i       (clk       ),
    .rst_n_i     (rst_n     ),
    .req_i       (req       ),
    .we_i        (we        ),
    .addr_i      (addr      ),
    .wdata_i     (wdata     ),
    .be_i        (be        ),
    .gnt_o       (gnt       ),
    .rvalid_o    (rvalid    ),
    .rdata_o     (rdata     ),
    .ext_req_o   (ext_req   ),
    .ext_we_o    (ext_we    ),
    .ext_addr_o  (ext_addr  ),
    .ext_wdata_o (ext_wdata ),
    .ext_be_o    (ext_be    ),
    .ext_gnt_i   (ext_gnt   ),
    .ext_rvalid_i(ext_rvalid),
    .ext_rdata_i (ext_rdata ),
    .wake_up_o   (wake_up   ),
    .eoc_valid_o (eoc_valid )
  );

  // Response, wake-up and internal target monitors
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (rst_n && rvalid) begin
      rsp_data.push_back(rdata);
      rsp_cycle.push_back(cycle);
    end
    if (wake_up != '0) begin
      wake_cycle.push_back(cycle);
      wake_val.push_back(wake_up);
    end
    if (dut.l2_rvalid || dut.rom_rvalid || dut.ctrl_rvalid) begin
      int_rsp_cnt <= int_rsp_cnt + 1;
    end
  end

  function automatic data_t merge_bytes(data_t old, data_t nw, strb_t b);
    data_t r;
    r = old;
    for (int i = 0; i < 4; i++) begin
      if (b[i]) r[8*i +: 8] = nw[8*i +: 8];
    end
    return r;
  endfunction

  // External target model where unwritten words read as zero
  initial begin : ext_responder
    data_t word;
    int    idx;
    ext_gnt    <= 1'b0;
    ext_rvalid <= 1'b0;
    ext_rdata  <= '0;
    forever begin
      @(posedge clk);
      if (rst_n && ext_req) begin
        idx = ext_cnt % 64;
        repeat (grant_delay[idx]) @(posedge clk);
        ext_gnt <= 1'b1;
        @(posedge clk); // Accepting edge
        ext_gnt    <= 1'b0;
        ext_cnt++;
        last_we    = ext_we;
        last_addr  = ext_addr;
        last_wdata = ext_wdata;
        last_be    = ext_be;
        word = ext_mem.exists(ext_addr) ? ext_mem[ext_addr] : '0;
        if (ext_we) begin
          word = merge_bytes(word, ext_wdata, ext_be);
          ext_mem[ext_addr] = word;
        end
        repeat (resp_delay[idx] - 1) @(posedge clk);
        ext_rdata  <= word;
        ext_rvalid <= 1'b1;
        @(posedge clk);
        ext_rvalid <= 1'b0;
      end
    end
  end

  task automatic timeout_error(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    errors++;
  endtask

  task automatic compare(input data_t got, input data_t exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Holds the request until granted and returns the accepting cycle
  task automatic send(input logic w, input addr_t a, input data_t d, input strb_t b,
                      output int acc);
    int n;
    n = 0;
    req   <= 1'b1;
    we    <= w;
    addr  <= a;
    wdata <= d;
    be    <= b;
    do begin
      @(posedge clk);
      n++;
    end while (!gnt && n < Timeout);
    if (!gnt) timeout_error($sformatf("request to %h was never granted", a));
    acc = cycle;
  endtask

  task automatic release_bus();
    req <= 1'b0;
  endtask

  task automatic collect_response(output data_t d, output int rc);
    int n;
    n = 0;
    while (rsp_data.size() == 0 && n < Timeout) begin
      @(posedge clk);
      n++;
    end
    if (rsp_data.size() == 0) begin
      timeout_error("the DUT gave no response");
      d  = 'x;
      rc = -1;
    end else begin
      d  = rsp_data.pop_front();
      rc = rsp_cycle.pop_front();
    end
  endtask

  task automatic access(input logic w, input addr_t a, input data_t d, input strb_t b,
                        output data_t rd, output int acc, output int rc);
    send(w, a, d, b, acc);
    release_bus();
    collect_response(rd, rc);
  endtask

  task automatic report_test(input string name);
    idle(2);
    compare(data_t'(rsp_data.size()), '0, {name, ": responses left over"});
    $display("%-26s done, %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  task automatic l2_round_trip();
    data_t d, rd;
    strb_t b;
    int    acc, rc;
    for (int i = 0; i < 16; i++) begin
      d = $random(seed);
      access(1'b1, L2BaseAddr + addr_t'(4 * i), d, 4'hF, rd, acc, rc);
      l2_model[i] = d;
      compare(data_t'(rc - acc), 32'd1, "L2 write latency");
    end
    for (int i = 0; i < 16; i += 3) begin
      d = $random(seed);
      b = 4'($random(seed));
      access(1'b1, L2BaseAddr + addr_t'(4 * i), d, b, rd, acc, rc);
      l2_model[i] = merge_bytes(l2_model[i], d, b);
    end
    for (int i = 0; i < 16; i++) begin
      access(1'b0, L2BaseAddr + addr_t'(4 * i), '0, 4'hF, rd, acc, rc);
      compare(rd, l2_model[i], $sformatf("L2 word %0d", i));
      compare(data_t'(rc - acc), 32'd1, "L2 read latency");
    end
    report_test("l2_round_trip");
  endtask

  task automatic bootrom_reads();
    int    words [4];
    data_t rd;
    int    acc, rc;
    words = '{0, 5, 15, 16};
    for (int j = 0; j < 4; j++) begin
      access(1'b0, BootromBaseAddr + addr_t'(4 * words[j]), '0, 4'hF, rd, acc, rc);
      compare(rd, {BootromTag, 16'(words[j] % 16)}, $sformatf("ROM word %0d", words[j]));
      compare(data_t'(rc - acc), 32'd1, "ROM read latency");
    end
    access(1'b1, BootromBaseAddr + 32'h14, 32'hFFFF_FFFF, 4'hF, rd, acc, rc);
    access(1'b0, BootromBaseAddr + 32'h14, '0, 4'hF, rd, acc, rc);
    compare(rd, 32'hB007_0005, "ROM word 5 after a write");
    report_test("bootrom_reads");
  endtask

  task automatic ctrl_register_access();
    core_mask_t mask;
    data_t      d, rd;
    int         acc, rc;
    mask = 8'($random(seed)) | 8'h01;
    wake_cycle.delete();
    wake_val.delete();
    access(1'b1, CtrlBaseAddr + addr_t'(CtrlWakeUpOffs), {24'h0, mask}, 4'hF, rd, acc, rc);
    idle(2);
    compare(data_t'(wake_cycle.size()), 32'd1, "wake-up pulse cycles");
    if (wake_cycle.size() > 0) begin
      compare(data_t'(wake_cycle[0]), data_t'(acc + 1), "wake-up pulse cycle");
      compare(data_t'(wake_val[0]), data_t'(mask), "wake-up mask");
    end
    d = data_t'($random(seed)) | 32'h1;
    access(1'b1, CtrlBaseAddr + addr_t'(CtrlEocOffs), d, 4'hF, rd, acc, rc);
    compare(data_t'(eoc_valid), 32'd1, "EOC flag after writing 1");
    access(1'b0, CtrlBaseAddr + addr_t'(CtrlEocOffs), '0, 4'hF, rd, acc, rc);
    compare(rd, d, "EOC register read");
    access(1'b1, CtrlBaseAddr + addr_t'(CtrlEocOffs), '0, 4'hF, rd, acc, rc);
    compare(data_t'(eoc_valid), '0, "EOC flag after writing 0");
    access(1'b0, CtrlBaseAddr + addr_t'(CtrlNumCoresOffs), '0, 4'hF, rd, acc, rc);
    compare(rd, 32'd8, "core count");
    access(1'b0, CtrlBaseAddr + addr_t'(CtrlWakeUpOffs), '0, 4'hF, rd, acc, rc);
    compare(rd, '0, "wake-up register read");
    report_test("ctrl_register_access");
  endtask

  task automatic external_forwarding();
    addr_t a;
    data_t d, rd;
    strb_t b;
    int    acc, rc, base, cnt0;
    idle(2);
    base = int_rsp_cnt;
    for (int j = 0; j < 2; j++) begin
      a    = (j == 0) ? 32'h1000_0000 : 32'hC000_0000;
      d    = $random(seed);
      b    = 4'($random(seed)) | 4'h1;
      cnt0 = ext_cnt;
      access(1'b1, a, d, b, rd, acc, rc);
      compare(data_t'(ext_cnt), data_t'(cnt0 + 1), "external write count");
      compare({31'h0, last_we}, 32'd1, "external write strobe");
      compare(last_addr, a, "external write address");
      compare(last_wdata, d, "external write data");
      compare(data_t'(last_be), data_t'(b), "external byte enables");
      access(1'b0, a, '0, 4'hF, rd, acc, rc);
      compare({31'h0, last_we}, '0, "external read strobe");
      compare(last_addr, a, "external read address");
      compare(rd, merge_bytes('0, d, b), "external read data");
      if (j == 0) ext_word0 = merge_bytes('0, d, b);
    end
    idle(2);
    compare(data_t'(int_rsp_cnt), data_t'(base), "internal responses to external requests");
    report_test("external_forwarding");
  endtask

  task automatic ordering_and_backpressure();
    data_t rd;
    int    acc [4];
    int    rc, acc_ext, acc_l2, rc_ext, rc_l2;
    for (int i = 0; i < 4; i++) begin
      send(1'b0, L2BaseAddr + addr_t'(4 * i), '0, 4'hF, acc[i]);
    end
    release_bus();
    for (int i = 0; i < 4; i++) begin
      collect_response(rd, rc);
      compare(rd, l2_model[i], $sformatf("back-to-back L2 read %0d", i));
      compare(data_t'(acc[i]), data_t'(acc[0] + i), "back-to-back grant cycle");
      compare(data_t'(rc), data_t'(acc[0] + 1 + i), "back-to-back response cycle");
    end
    send(1'b0, 32'h1000_0000, '0, 4'hF, acc_ext);
    send(1'b0, L2BaseAddr, '0, 4'hF, acc_l2);
    release_bus();
    collect_response(rd, rc_ext);
    compare(rd, ext_word0, "external read answered first");
    collect_response(rd, rc_l2);
    compare(rd, l2_model[0], "L2 read answered second");
    compare(data_t'(acc_l2 > rc_ext), 32'd1, "L2 grant held until external response");
    compare(data_t'(rc_l2), data_t'(acc_l2 + 1), "L2 response after held grant");
    report_test("ordering_and_backpressure");
  endtask

  initial begin : main
    int n;
    req   <= 1'b0;
    we    <= 1'b0;
    addr  <= '0;
    wdata <= '0;
    be    <= '0;
    seed = 32'h07a2_fa0a;
    for (int i = 0; i < 64; i++) begin
      grant_delay[i] = $random(seed) & 3;      // 0 to 3 cycles
      resp_delay[i]  = 1 + ($random(seed) & 3); // 1 to 4 cycles
    end
    n = 0;
    @(posedge clk);
    while (!rst_n && n < Timeout) begin
      @(posedge clk);
      n++;
    end
    if (!rst_n) timeout_error("reset was never released");
    compare(data_t'({rvalid, ext_req, eoc_valid}), '0, "strobes after reset");
    compare(data_t'(wake_up), '0, "wake-up mask after reset");
    l2_round_trip();
    bootrom_reads();
    ctrl_register_access();
    external_forwarding();
    ordering_and_backpressure();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_mempool_system
